/* verilog/zynq_shell_pkg.sv */
package zynq_shell_pkg;

  ////////////////////
  // widths
  ////////////////////
  localparam int axil_data_width_gp = 32;
  localparam int axil_addr_width_gp = 10;
  localparam int reg_idx_width_gp   = 8;
  localparam int rom_els_gp         = 8;
  localparam int rom_addr_width_gp  = 3;

  typedef logic [axil_data_width_gp-1:0] axil_data_t;
  typedef logic [axil_addr_width_gp-1:0] axil_addr_t;
  typedef logic [reg_idx_width_gp-1:0]   reg_idx_t;
  typedef logic [rom_addr_width_gp-1:0]  rom_addr_t;

  ////////////////////
  // register map
  ////////////////////
  // write side
  localparam reg_idx_t csr_reset_gp       = 8'd0;
  localparam reg_idx_t csr_tag_gp         = 8'd1;
  localparam reg_idx_t csr_rom_addr_gp    = 8'd2;
  localparam reg_idx_t wr_host_req_gp     = 8'd3;
  localparam reg_idx_t wr_host_rsp_gp     = 8'd4;
  // read side, csrs read back at 0 to 2
  localparam reg_idx_t rd_rom_data_gp     = 8'd3;
  localparam reg_idx_t rd_tag_busy_gp     = 8'd4;
  localparam reg_idx_t rd_mc_req_gp       = 8'd5;
  localparam reg_idx_t rd_mc_rsp_gp       = 8'd6;
  localparam reg_idx_t rd_mc_req_count_gp = 8'd7;
  localparam reg_idx_t rd_mc_rsp_count_gp = 8'd8;
  localparam reg_idx_t rd_host_req_free_gp = 8'd9;
  localparam reg_idx_t rd_host_rsp_free_gp = 8'd10;

  // one register access, issued in the handshake cycle
  typedef struct packed {
    logic       we;
    logic       re;
    reg_idx_t   idx;
    axil_data_t wdata;
  } reg_req_s;

  typedef struct packed {
    axil_data_t rdata;
    logic       err;
  } reg_rsp_s;

  typedef enum logic [1:0] {
    e_tag_idle,
    e_tag_setup,
    e_tag_high
  } tag_state_e;

  // tiles x, tiles y, ways, sets, block words, reset depth, version, magic
  localparam axil_data_t rom_table_gp [rom_els_gp] = '{
    32'd4, 32'd4, 32'd8, 32'd64, 32'd8, 32'd3, 32'h0001_0000, 32'h5a17_c0de
  };

endpackage

/* verilog/axil_slave.sv */
`timescale 1ns/1ps

module axil_slave
  (input                               aclk
   , input                             arst_n_i

   , input  zynq_shell_pkg::axil_addr_t s00_axi_awaddr_i
   , input                             s00_axi_awvalid_i
   , output logic                      s00_axi_awready_o
   , input  zynq_shell_pkg::axil_data_t s00_axi_wdata_i
   , input                             s00_axi_wvalid_i
   , output logic                      s00_axi_wready_o
   , output logic [1:0]                s00_axi_bresp_o
   , output logic                      s00_axi_bvalid_o
   , input                             s00_axi_bready_i
   , input  zynq_shell_pkg::axil_addr_t s00_axi_araddr_i
   , input                             s00_axi_arvalid_i
   , output logic                      s00_axi_arready_o
   , output zynq_shell_pkg::axil_data_t s00_axi_rdata_o
   , output logic [1:0]                s00_axi_rresp_o
   , output logic                      s00_axi_rvalid_o
   , input                             s00_axi_rready_i

   , output zynq_shell_pkg::reg_req_s  req_o
   , input  zynq_shell_pkg::reg_rsp_s  rsp_i
   );

  import zynq_shell_pkg::*;

  logic       wr_fire, rd_fire;
  logic       bvalid_r, rvalid_r;
  logic [1:0] bresp_r;
  axil_data_t rdata_r;

  // aw and w taken together, only with no response pending
  assign wr_fire = s00_axi_awvalid_i & s00_axi_wvalid_i & ~bvalid_r;
  // write wins the cycle
  assign rd_fire = s00_axi_arvalid_i & ~rvalid_r & ~wr_fire;

  assign s00_axi_awready_o = wr_fire;
  assign s00_axi_wready_o  = wr_fire;
  assign s00_axi_arready_o = rd_fire;

  assign req_o.we    = wr_fire;
  assign req_o.re    = rd_fire;
  assign req_o.idx   = wr_fire ? reg_idx_t'(s00_axi_awaddr_i >> 2)
                               : reg_idx_t'(s00_axi_araddr_i >> 2);
  assign req_o.wdata = s00_axi_wdata_i;

  always_ff @(posedge aclk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      bvalid_r <= 1'b0;
      rvalid_r <= 1'b0;
    end else begin
      if (wr_fire)
        bvalid_r <= 1'b1;
      else if (s00_axi_bready_i)
        bvalid_r <= 1'b0;
      if (rd_fire)
        rvalid_r <= 1'b1;
      else if (s00_axi_rready_i)
        rvalid_r <= 1'b0;
    end
  end

  always_ff @(posedge aclk) begin
    if (wr_fire)
      bresp_r <= rsp_i.err ? 2'b10 : 2'b00;
    if (rd_fire)
      rdata_r <= rsp_i.rdata;
  end

  assign s00_axi_bvalid_o = bvalid_r;
  assign s00_axi_bresp_o  = bresp_r;
  assign s00_axi_rvalid_o = rvalid_r;
  assign s00_axi_rdata_o  = rdata_r;
  // reads never fail
  assign s00_axi_rresp_o  = 2'b00;

  // responses wait for the host
  assert property (@(posedge aclk) disable iff (!arst_n_i)
    s00_axi_bvalid_o && !s00_axi_bready_i |=> s00_axi_bvalid_o);
  assert property (@(posedge aclk) disable iff (!arst_n_i)
    s00_axi_rvalid_o && !s00_axi_rready_i |=> s00_axi_rvalid_o && $stable(s00_axi_rdata_o));

endmodule

/* verilog/shell_regs.sv */
`timescale 1ns/1ps

module shell_regs
  #(parameter int fifo_els_p = 4
    , localparam int count_width_lp = $clog2(fifo_els_p+1)
    )
  (input                                aclk
   , input                              arst_n_i

   , input  zynq_shell_pkg::reg_req_s   req_i
   , output zynq_shell_pkg::reg_rsp_s   rsp_o

   , output logic                       host_req_push_o
   , output zynq_shell_pkg::axil_data_t host_req_data_o
   , input  [count_width_lp-1:0]        host_req_count_i
   , output logic                       host_rsp_push_o
   , output zynq_shell_pkg::axil_data_t host_rsp_data_o
   , input  [count_width_lp-1:0]        host_rsp_count_i

   , output logic                       mc_req_pop_o
   , input  zynq_shell_pkg::axil_data_t mc_req_data_i
   , input  [count_width_lp-1:0]        mc_req_count_i
   , output logic                       mc_rsp_pop_o
   , input  zynq_shell_pkg::axil_data_t mc_rsp_data_i
   , input  [count_width_lp-1:0]        mc_rsp_count_i

   , output logic                       tag_v_o
   , output logic                       tag_bit_o
   , input                              tag_busy_i
   , output logic                       reset_release_o
   , output zynq_shell_pkg::rom_addr_t  rom_addr_o
   , input  zynq_shell_pkg::axil_data_t rom_data_i
   );

  import zynq_shell_pkg::*;

  logic       reset_r, tag_r;
  rom_addr_t  rom_addr_r;
  logic       host_req_full, host_rsp_full;
  logic       wr_err;
  axil_data_t rd_mux;

  ////////////////////
  // write decode
  ////////////////////
  always_ff @(posedge aclk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      reset_r    <= 1'b0;
      tag_r      <= 1'b0;
      rom_addr_r <= '0;
    end else if (req_i.we) begin
      if (req_i.idx == csr_reset_gp)
        reset_r <= req_i.wdata[0];
      if (req_i.idx == csr_tag_gp)
        tag_r <= req_i.wdata[0];
      if (req_i.idx == csr_rom_addr_gp)
        rom_addr_r <= rom_addr_t'(req_i.wdata);
    end
  end

  assign host_req_full = (host_req_count_i == count_width_lp'(fifo_els_p));
  assign host_rsp_full = (host_rsp_count_i == count_width_lp'(fifo_els_p));

  // full pushes are dropped and flagged
  assign host_req_push_o = req_i.we & (req_i.idx == wr_host_req_gp) & ~host_req_full;
  assign host_rsp_push_o = req_i.we & (req_i.idx == wr_host_rsp_gp) & ~host_rsp_full;
  assign host_req_data_o = req_i.wdata;
  assign host_rsp_data_o = req_i.wdata;

  assign wr_err = req_i.we & ((req_i.idx > wr_host_rsp_gp)
                              | ((req_i.idx == wr_host_req_gp) & host_req_full)
                              | ((req_i.idx == wr_host_rsp_gp) & host_rsp_full));

  // tag strobe on every write to the tag csr
  assign tag_v_o   = req_i.we & (req_i.idx == csr_tag_gp);
  assign tag_bit_o = req_i.wdata[0];

  assign reset_release_o = reset_r;
  assign rom_addr_o      = rom_addr_r;

  ////////////////////
  // read decode
  ////////////////////
  assign mc_req_pop_o = req_i.re & (req_i.idx == rd_mc_req_gp) & (mc_req_count_i != '0);
  assign mc_rsp_pop_o = req_i.re & (req_i.idx == rd_mc_rsp_gp) & (mc_rsp_count_i != '0);

  always_comb begin
    rd_mux = '0;
    case (req_i.idx)
      csr_reset_gp:        rd_mux = axil_data_t'(reset_r);
      csr_tag_gp:          rd_mux = axil_data_t'(tag_r);
      csr_rom_addr_gp:     rd_mux = axil_data_t'(rom_addr_r);
      rd_rom_data_gp:      rd_mux = rom_data_i;
      rd_tag_busy_gp:      rd_mux = axil_data_t'(tag_busy_i);
      // empty queue reads as zero
      rd_mc_req_gp:        rd_mux = (mc_req_count_i != '0) ? mc_req_data_i : '0;
      rd_mc_rsp_gp:        rd_mux = (mc_rsp_count_i != '0) ? mc_rsp_data_i : '0;
      rd_mc_req_count_gp:  rd_mux = axil_data_t'(mc_req_count_i);
      rd_mc_rsp_count_gp:  rd_mux = axil_data_t'(mc_rsp_count_i);
      rd_host_req_free_gp: rd_mux = axil_data_t'(fifo_els_p) - axil_data_t'(host_req_count_i);
      rd_host_rsp_free_gp: rd_mux = axil_data_t'(fifo_els_p) - axil_data_t'(host_rsp_count_i);
      default:             rd_mux = '0;
    endcase
  end

  assign rsp_o.rdata = rd_mux;
  assign rsp_o.err   = wr_err;

endmodule

/* verilog/host_fifo.sv */
`timescale 1ns/1ps

module host_fifo
  #(parameter int els_p = 4
    , localparam int ptr_width_lp   = (els_p > 1) ? $clog2(els_p) : 1
    , localparam int count_width_lp = $clog2(els_p+1)
    )
  (input                                aclk
   , input                              arst_n_i

   , input                              push_i
   , input  zynq_shell_pkg::axil_data_t push_data_i
   , output logic                       full_o

   , input                              pop_i
   , output zynq_shell_pkg::axil_data_t pop_data_o
   , output logic                       empty_o
   , output logic [count_width_lp-1:0]  count_o
   );

  import zynq_shell_pkg::*;

  axil_data_t                mem_r [els_p];
  logic [ptr_width_lp-1:0]   wptr_r, rptr_r;
  logic [count_width_lp-1:0] count_r;

  function automatic logic [ptr_width_lp-1:0] ptr_next(logic [ptr_width_lp-1:0] ptr);
    return (ptr == ptr_width_lp'(els_p-1)) ? '0 : ptr + 1'b1;
  endfunction

  always_ff @(posedge aclk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wptr_r  <= '0;
      rptr_r  <= '0;
      count_r <= '0;
    end else begin
      if (push_i)
        wptr_r <= ptr_next(wptr_r);
      if (pop_i)
        rptr_r <= ptr_next(rptr_r);
      if (push_i && !pop_i)
        count_r <= count_r + 1'b1;
      else if (pop_i && !push_i)
        count_r <= count_r - 1'b1;
    end
  end

  always_ff @(posedge aclk) begin
    if (push_i)
      mem_r[wptr_r] <= push_data_i;
  end

  assign pop_data_o = mem_r[rptr_r];
  assign full_o     = (count_r == count_width_lp'(els_p));
  assign empty_o    = (count_r == '0);
  assign count_o    = count_r;

  // both callers must respect full and empty
  assert property (@(posedge aclk) disable iff (!arst_n_i)
    !(push_i && full_o) && !(pop_i && empty_o));

endmodule

/* verilog/tag_bitbang.sv */
`timescale 1ns/1ps

module tag_bitbang
  (input          aclk
   , input        arst_n_i
   , input        v_i
   , input        bit_i
   , output logic busy_o
   , output logic tag_clk_o
   , output logic tag_data_o
   );

  import zynq_shell_pkg::*;

  tag_state_e state_r, state_n;
  logic       tag_clk_r, tag_data_r;

  always_comb begin
    state_n = state_r;
    case (state_r)
      e_tag_idle:  if (v_i) state_n = e_tag_setup;
      e_tag_setup: state_n = e_tag_high;
      e_tag_high:  state_n = e_tag_idle;
      default:     state_n = e_tag_idle;
    endcase
  end

  always_ff @(posedge aclk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_r    <= e_tag_idle;
      tag_clk_r  <= 1'b0;
      tag_data_r <= 1'b0;
    end else begin
      state_r   <= state_n;
      // one high cycle right after setup
      tag_clk_r <= (state_r == e_tag_setup);
      // strobes while busy are dropped
      if (v_i && state_r == e_tag_idle)
        tag_data_r <= bit_i;
    end
  end

  assign busy_o     = (state_r != e_tag_idle);
  assign tag_clk_o  = tag_clk_r;
  assign tag_data_o = tag_data_r;

  // data is settled a full cycle before the clock edge
  assert property (@(posedge aclk) disable iff (!arst_n_i)
    $rose(tag_clk_o) |-> $past(state_r) == e_tag_setup && $stable(tag_data_o));

endmodule

/* verilog/machine_ctrl.sv */
`timescale 1ns/1ps

module machine_ctrl
  #(parameter int reset_depth_p = 3)
  (input                                aclk
   , input                              arst_n_i
   , input                              reset_release_i
   , input  zynq_shell_pkg::rom_addr_t  rom_addr_i
   , output zynq_shell_pkg::axil_data_t rom_data_o
   , output logic                       sys_reset_o
   );

  import zynq_shell_pkg::*;

  logic [reset_depth_p-1:0] chain_r;

  // held in reset until the host lets go
  always_ff @(posedge aclk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      chain_r <= '1;
    end else begin
      chain_r[0] <= ~reset_release_i;
      for (int i = 1; i < reset_depth_p; i++) begin
        chain_r[i] <= chain_r[i-1];
      end
    end
  end

  assign sys_reset_o = chain_r[reset_depth_p-1];

  // machine parameters
  assign rom_data_o = rom_table_gp[rom_addr_i];

endmodule

/* verilog/zynq_top.sv */
`timescale 1ns/1ps

module zynq_top
  #(parameter int fifo_els_p = 4
    , parameter int reset_depth_p = 3
    )
  (input                                aclk
   , input                              arst_n_i

   , input  zynq_shell_pkg::axil_addr_t s00_axi_awaddr_i
   , input                              s00_axi_awvalid_i
   , output logic                       s00_axi_awready_o
   , input  zynq_shell_pkg::axil_data_t s00_axi_wdata_i
   , input                              s00_axi_wvalid_i
   , output logic                       s00_axi_wready_o
   , output logic [1:0]                 s00_axi_bresp_o
   , output logic                       s00_axi_bvalid_o
   , input                              s00_axi_bready_i
   , input  zynq_shell_pkg::axil_addr_t s00_axi_araddr_i
   , input                              s00_axi_arvalid_i
   , output logic                       s00_axi_arready_o
   , output zynq_shell_pkg::axil_data_t s00_axi_rdata_o
   , output logic [1:0]                 s00_axi_rresp_o
   , output logic                       s00_axi_rvalid_o
   , input                              s00_axi_rready_i

   , output zynq_shell_pkg::axil_data_t host_req_data_o
   , output logic                       host_req_v_o
   , input                              host_req_ready_i
   , output zynq_shell_pkg::axil_data_t host_rsp_data_o
   , output logic                       host_rsp_v_o
   , input                              host_rsp_ready_i

   , input  zynq_shell_pkg::axil_data_t mc_req_data_i
   , input                              mc_req_v_i
   , output logic                       mc_req_ready_o
   , input  zynq_shell_pkg::axil_data_t mc_rsp_data_i
   , input                              mc_rsp_v_i
   , output logic                       mc_rsp_ready_o

   , output logic                       sys_reset_o
   , output logic                       tag_clk_o
   , output logic                       tag_data_o
   );

  import zynq_shell_pkg::*;

  localparam int count_width_lp = $clog2(fifo_els_p+1);

  reg_req_s req_lo;
  reg_rsp_s rsp_li;

  logic                      host_req_push_lo, host_rsp_push_lo;
  axil_data_t                host_req_wdata_lo, host_rsp_wdata_lo;
  logic [count_width_lp-1:0] host_req_count_lo, host_rsp_count_lo;
  logic                      host_req_empty_lo, host_rsp_empty_lo;

  logic                      mc_req_pop_lo, mc_rsp_pop_lo;
  axil_data_t                mc_req_head_lo, mc_rsp_head_lo;
  logic [count_width_lp-1:0] mc_req_count_lo, mc_rsp_count_lo;
  logic                      mc_req_full_lo, mc_rsp_full_lo;

  logic       tag_v_lo, tag_bit_lo, tag_busy_lo;
  logic       reset_release_lo;
  rom_addr_t  rom_addr_lo;
  axil_data_t rom_data_lo;

  ////////////////////
  // host bus
  ////////////////////
  axil_slave axil
    (.aclk(aclk), .arst_n_i(arst_n_i)
     ,.s00_axi_awaddr_i(s00_axi_awaddr_i), .s00_axi_awvalid_i(s00_axi_awvalid_i)
     ,.s00_axi_awready_o(s00_axi_awready_o)
     ,.s00_axi_wdata_i(s00_axi_wdata_i), .s00_axi_wvalid_i(s00_axi_wvalid_i)
     ,.s00_axi_wready_o(s00_axi_wready_o)
     ,.s00_axi_bresp_o(s00_axi_bresp_o), .s00_axi_bvalid_o(s00_axi_bvalid_o)
     ,.s00_axi_bready_i(s00_axi_bready_i)
     ,.s00_axi_araddr_i(s00_axi_araddr_i), .s00_axi_arvalid_i(s00_axi_arvalid_i)
     ,.s00_axi_arready_o(s00_axi_arready_o)
     ,.s00_axi_rdata_o(s00_axi_rdata_o), .s00_axi_rresp_o(s00_axi_rresp_o)
     ,.s00_axi_rvalid_o(s00_axi_rvalid_o), .s00_axi_rready_i(s00_axi_rready_i)
     ,.req_o(req_lo), .rsp_i(rsp_li)
     );

  shell_regs #(.fifo_els_p(fifo_els_p)) regs
    (.aclk(aclk), .arst_n_i(arst_n_i)
     ,.req_i(req_lo), .rsp_o(rsp_li)
     ,.host_req_push_o(host_req_push_lo), .host_req_data_o(host_req_wdata_lo)
     ,.host_req_count_i(host_req_count_lo)
     ,.host_rsp_push_o(host_rsp_push_lo), .host_rsp_data_o(host_rsp_wdata_lo)
     ,.host_rsp_count_i(host_rsp_count_lo)
     ,.mc_req_pop_o(mc_req_pop_lo), .mc_req_data_i(mc_req_head_lo)
     ,.mc_req_count_i(mc_req_count_lo)
     ,.mc_rsp_pop_o(mc_rsp_pop_lo), .mc_rsp_data_i(mc_rsp_head_lo)
     ,.mc_rsp_count_i(mc_rsp_count_lo)
     ,.tag_v_o(tag_v_lo), .tag_bit_o(tag_bit_lo), .tag_busy_i(tag_busy_lo)
     ,.reset_release_o(reset_release_lo)
     ,.rom_addr_o(rom_addr_lo), .rom_data_i(rom_data_lo)
     );

  ////////////////////
  // queues
  ////////////////////
  // host to fabric, drained by the stream handshake
  host_fifo #(.els_p(fifo_els_p)) host_req_fifo
    (.aclk(aclk), .arst_n_i(arst_n_i)
     ,.push_i(host_req_push_lo), .push_data_i(host_req_wdata_lo), .full_o()
     ,.pop_i(host_req_v_o & host_req_ready_i), .pop_data_o(host_req_data_o)
     ,.empty_o(host_req_empty_lo), .count_o(host_req_count_lo)
     );

  host_fifo #(.els_p(fifo_els_p)) host_rsp_fifo
    (.aclk(aclk), .arst_n_i(arst_n_i)
     ,.push_i(host_rsp_push_lo), .push_data_i(host_rsp_wdata_lo), .full_o()
     ,.pop_i(host_rsp_v_o & host_rsp_ready_i), .pop_data_o(host_rsp_data_o)
     ,.empty_o(host_rsp_empty_lo), .count_o(host_rsp_count_lo)
     );

  assign host_req_v_o = ~host_req_empty_lo;
  assign host_rsp_v_o = ~host_rsp_empty_lo;

  // fabric to host, filled by the stream handshake
  host_fifo #(.els_p(fifo_els_p)) mc_req_fifo
    (.aclk(aclk), .arst_n_i(arst_n_i)
     ,.push_i(mc_req_v_i & mc_req_ready_o), .push_data_i(mc_req_data_i)
     ,.full_o(mc_req_full_lo)
     ,.pop_i(mc_req_pop_lo), .pop_data_o(mc_req_head_lo)
     ,.empty_o(), .count_o(mc_req_count_lo)
     );

  host_fifo #(.els_p(fifo_els_p)) mc_rsp_fifo
    (.aclk(aclk), .arst_n_i(arst_n_i)
     ,.push_i(mc_rsp_v_i & mc_rsp_ready_o), .push_data_i(mc_rsp_data_i)
     ,.full_o(mc_rsp_full_lo)
     ,.pop_i(mc_rsp_pop_lo), .pop_data_o(mc_rsp_head_lo)
     ,.empty_o(), .count_o(mc_rsp_count_lo)
     );

  assign mc_req_ready_o = ~mc_req_full_lo;
  assign mc_rsp_ready_o = ~mc_rsp_full_lo;

  ////////////////////
  // tag and control
  ////////////////////
  tag_bitbang bb
    (.aclk(aclk), .arst_n_i(arst_n_i)
     ,.v_i(tag_v_lo), .bit_i(tag_bit_lo), .busy_o(tag_busy_lo)
     ,.tag_clk_o(tag_clk_o), .tag_data_o(tag_data_o)
     );

  machine_ctrl #(.reset_depth_p(reset_depth_p)) ctrl
    (.aclk(aclk), .arst_n_i(arst_n_i)
     ,.reset_release_i(reset_release_lo)
     ,.rom_addr_i(rom_addr_lo), .rom_data_o(rom_data_lo)
     ,.sys_reset_o(sys_reset_o)
     );

endmodule

/* test/axil_host.svh */
`ifndef AXIL_HOST_SVH
`define AXIL_HOST_SVH

////////////////////
// axi-lite host
////////////////////
// inputs change on the rising edge, outputs are sampled on the falling edge

// one write through aw, w and b
task automatic write_reg(input reg_idx_t idx, input axil_data_t data, output logic [1:0] resp);
  @(posedge aclk);
  awaddr  <= axil_addr_t'({idx, 2'b00});
  awvalid <= 1'b1;
  wdata   <= data;
  wvalid  <= 1'b1;
  bready  <= 1'b1;
  @(negedge aclk);
  while (!(awready && wready)) begin
    @(negedge aclk);
  end
  @(posedge aclk);
  awvalid <= 1'b0;
  wvalid  <= 1'b0;
  @(negedge aclk);
  while (!bvalid) begin
    @(negedge aclk);
  end
  resp = bresp;
  @(posedge aclk);
  bready <= 1'b0;
endtask

// one read through ar and r
task automatic read_reg(input reg_idx_t idx, output axil_data_t data, output logic [1:0] resp);
  @(posedge aclk);
  araddr  <= axil_addr_t'({idx, 2'b00});
  arvalid <= 1'b1;
  rready  <= 1'b1;
  @(negedge aclk);
  while (!arready) begin
    @(negedge aclk);
  end
  @(posedge aclk);
  arvalid <= 1'b0;
  @(negedge aclk);
  while (!rvalid) begin
    @(negedge aclk);
  end
  data = rdata;
  resp = rresp;
  @(posedge aclk);
  rready <= 1'b0;
endtask

`endif

/* test/zynq_top_tb.sv */
`timescale 1ns/1ps

module zynq_top_tb;

  import zynq_shell_pkg::*;

  localparam int fifo_els_lp    = 4;
  localparam int reset_depth_lp = 3;
  localparam int clk_period_lp  = 4;
  // watchdog budget
  localparam int num_tests_lp       = 6;
  localparam int cycles_per_test_lp = 400;

  localparam logic [1:0] okay_lp   = 2'b00;
  localparam logic [1:0] slverr_lp = 2'b10;

  logic       aclk, arst_n_i;
  axil_addr_t awaddr, araddr;
  axil_data_t wdata, rdata;
  logic       awvalid, awready, wvalid, wready, bvalid, bready;
  logic       arvalid, arready, rvalid, rready;
  logic [1:0] bresp, rresp;

  axil_data_t host_req_data, host_rsp_data, mc_req_data, mc_rsp_data;
  logic       host_req_v, host_req_ready, host_rsp_v, host_rsp_ready;
  logic       mc_req_v, mc_req_ready, mc_rsp_v, mc_rsp_ready;
  logic       sys_reset, tag_clk, tag_data;

  logic tag_samples [$];

  `include "axil_host.svh"

  zynq_top #(.fifo_els_p(fifo_els_lp), .reset_depth_p(reset_depth_lp)) dut
    (.aclk(aclk), .arst_n_i(arst_n_i)
     ,.s00_axi_awaddr_i(awaddr), .s00_axi_awvalid_i(awvalid), .s00_axi_awready_o(awready)
     ,.s00_axi_wdata_i(wdata), .s00_axi_wvalid_i(wvalid), .s00_axi_wready_o(wready)
     ,.s00_axi_bresp_o(bresp), .s00_axi_bvalid_o(bvalid), .s00_axi_bready_i(bready)
     ,.s00_axi_araddr_i(araddr), .s00_axi_arvalid_i(arvalid), .s00_axi_arready_o(arready)
     ,.s00_axi_rdata_o(rdata), .s00_axi_rresp_o(rresp)
     ,.s00_axi_rvalid_o(rvalid), .s00_axi_rready_i(rready)
     ,.host_req_data_o(host_req_data), .host_req_v_o(host_req_v)
     ,.host_req_ready_i(host_req_ready)
     ,.host_rsp_data_o(host_rsp_data), .host_rsp_v_o(host_rsp_v)
     ,.host_rsp_ready_i(host_rsp_ready)
     ,.mc_req_data_i(mc_req_data), .mc_req_v_i(mc_req_v), .mc_req_ready_o(mc_req_ready)
     ,.mc_rsp_data_i(mc_rsp_data), .mc_rsp_v_i(mc_rsp_v), .mc_rsp_ready_o(mc_rsp_ready)
     ,.sys_reset_o(sys_reset), .tag_clk_o(tag_clk), .tag_data_o(tag_data)
     );

  initial begin
    aclk = 1'b0;
    forever #(clk_period_lp / 2) aclk = ~aclk;
  end

  // tag bits as the tag network captures them
  always @(posedge tag_clk) begin
    tag_samples.push_back(tag_data);
  end

  ////////////////////
  // checks
  ////////////////////
  task automatic report_mismatch(input string msg);
    $display("CHECK FAILED at %0t ns: %s", $time, msg);
    $display(">>> FAIL");
    $fatal(1, "stopped at the first failed check");
  endtask

  task automatic check_value(input axil_data_t got, input axil_data_t exp, input string what);
    assert (got === exp)
      else report_mismatch($sformatf("%s: got 0x%08h, expected 0x%08h", what, got, exp));
  endtask

  task automatic expect_write(input reg_idx_t idx, input axil_data_t data,
                              input logic [1:0] exp_resp);
    logic [1:0] resp;
    write_reg(idx, data, resp);
    check_value(axil_data_t'(resp), axil_data_t'(exp_resp),
                $sformatf("bresp of write to index %0d", idx));
  endtask

  task automatic expect_read(input reg_idx_t idx, input axil_data_t exp, input string what);
    axil_data_t data;
    logic [1:0] resp;
    read_reg(idx, data, resp);
    check_value(axil_data_t'(resp), axil_data_t'(okay_lp),
                $sformatf("rresp of read from index %0d", idx));
    check_value(data, exp, what);
  endtask

  task automatic wait_sys_reset(input logic level);
    for (int n = 0; n < reset_depth_lp + 2; n++) begin
      @(negedge aclk);
      if (sys_reset === level)
        break;
    end
    check_value(axil_data_t'(sys_reset), axil_data_t'(level), "sys_reset_o after the delay chain");
  endtask

  ////////////////////
  // tests
  ////////////////////
  task automatic reset_release_test();
    @(negedge aclk);
    check_value(axil_data_t'(sys_reset), 32'd1, "sys_reset_o after reset");
    check_value(axil_data_t'(tag_clk), 32'd0, "tag_clk_o after reset");
    check_value(axil_data_t'({host_req_v, host_rsp_v}), 32'd0, "host stream valids after reset");
    expect_write(csr_reset_gp, 32'd1, okay_lp);
    wait_sys_reset(1'b0);
    expect_read(csr_reset_gp, 32'd1, "reset release readback");
    expect_write(csr_reset_gp, 32'd0, okay_lp);
    wait_sys_reset(1'b1);
    expect_read(csr_reset_gp, 32'd0, "reset hold readback");
  endtask

  task automatic rom_readback_test();
    for (int a = 0; a < rom_els_gp; a++) begin
      expect_write(csr_rom_addr_gp, axil_data_t'(a), okay_lp);
      expect_read(rd_rom_data_gp, rom_table_gp[a], $sformatf("rom word %0d", a));
    end
  endtask

  task automatic host_queue_test();
    axil_data_t exp_req [$];
    axil_data_t exp_rsp [$];
    axil_data_t word;
    for (int i = 0; i <= fifo_els_lp; i++) begin
      word = axil_data_t'($urandom);
      if (i < fifo_els_lp) begin
        expect_write(wr_host_req_gp, word, okay_lp);
        exp_req.push_back(word);
        expect_read(rd_host_req_free_gp, axil_data_t'(fifo_els_lp - i - 1), "host req free");
      end else begin
        expect_write(wr_host_req_gp, word, slverr_lp);
      end
      word = axil_data_t'($urandom);
      if (i < fifo_els_lp) begin
        expect_write(wr_host_rsp_gp, word, okay_lp);
        exp_rsp.push_back(word);
        expect_read(rd_host_rsp_free_gp, axil_data_t'(fifo_els_lp - i - 1), "host rsp free");
      end else begin
        expect_write(wr_host_rsp_gp, word, slverr_lp);
      end
    end
    @(posedge aclk);
    host_req_ready <= 1'b1;
    host_rsp_ready <= 1'b1;
    // one word per cycle while ready stays high
    while (exp_req.size() > 0 || exp_rsp.size() > 0) begin
      @(negedge aclk);
      if (exp_req.size() > 0) begin
        check_value(axil_data_t'(host_req_v), 32'd1, "host req valid while words remain");
        check_value(host_req_data, exp_req.pop_front(), "host req stream word");
      end
      if (exp_rsp.size() > 0) begin
        check_value(axil_data_t'(host_rsp_v), 32'd1, "host rsp valid while words remain");
        check_value(host_rsp_data, exp_rsp.pop_front(), "host rsp stream word");
      end
    end
    @(negedge aclk);
    check_value(axil_data_t'({host_req_v, host_rsp_v}), 32'd0, "host streams after drain");
    @(posedge aclk);
    host_req_ready <= 1'b0;
    host_rsp_ready <= 1'b0;
  endtask

  task automatic mc_queue_test();
    axil_data_t exp_req [$];
    axil_data_t exp_rsp [$];
    axil_data_t req_word, rsp_word;
    logic       req_take, rsp_take;
    logic       req_on, rsp_on;
    req_on = 1'b1;
    rsp_on = 1'b1;
    @(posedge aclk);
    mc_req_v    <= 1'b1;
    mc_req_data <= axil_data_t'($urandom);
    mc_rsp_v    <= 1'b1;
    mc_rsp_data <= axil_data_t'($urandom);
    // offer words until each queue pushes back
    while (req_on || rsp_on) begin
      @(negedge aclk);
      req_take = mc_req_v && mc_req_ready;
      rsp_take = mc_rsp_v && mc_rsp_ready;
      req_word = mc_req_data;
      rsp_word = mc_rsp_data;
      @(posedge aclk);
      if (req_take) begin
        exp_req.push_back(req_word);
        mc_req_data <= axil_data_t'($urandom);
      end else begin
        mc_req_v <= 1'b0;
        req_on = 1'b0;
      end
      if (rsp_take) begin
        exp_rsp.push_back(rsp_word);
        mc_rsp_data <= axil_data_t'($urandom);
      end else begin
        mc_rsp_v <= 1'b0;
        rsp_on = 1'b0;
      end
    end
    expect_read(rd_mc_req_count_gp, axil_data_t'(fifo_els_lp), "mc req count when full");
    expect_read(rd_mc_rsp_count_gp, axil_data_t'(fifo_els_lp), "mc rsp count when full");
    while (exp_req.size() > 0) begin
      expect_read(rd_mc_req_gp, exp_req.pop_front(), "mc req pop");
    end
    while (exp_rsp.size() > 0) begin
      expect_read(rd_mc_rsp_gp, exp_rsp.pop_front(), "mc rsp pop");
    end
    expect_read(rd_mc_req_gp, 32'd0, "mc req pop when empty");
    expect_read(rd_mc_rsp_gp, 32'd0, "mc rsp pop when empty");
  endtask

  task automatic tag_serial_test();
    logic [7:0] bits;
    axil_data_t busy;
    logic [1:0] resp;
    bits = 8'($urandom);
    tag_samples.delete();
    for (int i = 0; i < 8; i++) begin
      // a strobe while busy would be lost
      do begin
        read_reg(rd_tag_busy_gp, busy, resp);
      end while (busy != 0);
      expect_write(csr_tag_gp, axil_data_t'(bits[i]), okay_lp);
    end
    expect_read(rd_tag_busy_gp, 32'd0, "tag busy after the last bit");
    while (tag_samples.size() < 8) begin
      @(negedge aclk);
    end
    check_value(axil_data_t'(tag_samples.size()), 32'd8, "number of tag clock pulses");
    for (int i = 0; i < 8; i++) begin
      check_value(axil_data_t'(tag_samples[i]), axil_data_t'(bits[i]),
                  $sformatf("tag bit %0d", i));
    end
  endtask

  task automatic error_resp_test();
    expect_write(8'd20, 32'hdead_beef, slverr_lp);
    expect_read(8'd20, 32'd0, "read of unmapped index 20");
  endtask

  ////////////////////
  // main
  ////////////////////
  initial begin
    void'($urandom(35));
    arst_n_i       = 1'b0;
    awaddr         = '0;
    awvalid        = 1'b0;
    wdata          = '0;
    wvalid         = 1'b0;
    bready         = 1'b0;
    araddr         = '0;
    arvalid        = 1'b0;
    rready         = 1'b0;
    host_req_ready = 1'b0;
    host_rsp_ready = 1'b0;
    mc_req_data    = '0;
    mc_req_v       = 1'b0;
    mc_rsp_data    = '0;
    mc_rsp_v       = 1'b0;
    repeat (5) @(posedge aclk);
    arst_n_i <= 1'b1;
    reset_release_test();
    rom_readback_test();
    host_queue_test();
    mc_queue_test();
    tag_serial_test();
    error_resp_test();
    $display(">>> PASS");
    $finish;
  end

  initial begin
    #(num_tests_lp * cycles_per_test_lp * clk_period_lp);
    $display("timeout: tests still running after %0d cycles",
             num_tests_lp * cycles_per_test_lp);
    $display(">>> FAIL");
    $fatal(1, "watchdog expired");
  end

endmodule

/* zynq_top.f */
+incdir+test
verilog/zynq_shell_pkg.sv
verilog/axil_slave.sv
verilog/shell_regs.sv
verilog/host_fifo.sv
verilog/tag_bitbang.sv
verilog/machine_ctrl.sv
verilog/zynq_top.sv
test/zynq_top_tb.sv

/* Makefile */
TOP := zynq_top_tb
LOG := sim.log

.PHONY: help test clean

help:
	@echo "make test   build with Verilator, run the testbench, check $(LOG)"
	@echo "make clean  remove obj_dir and $(LOG)"
	@echo "make help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f zynq_top.f -o $(TOP)
	-./obj_dir/$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q ">>> FAIL" $(LOG) || ! grep -q ">>> PASS" $(LOG); then \
	  echo "simulation failed"; \
	  exit 1; \
	else \
	  echo "simulation passed"; \
	fi

clean:
	rm -rf obj_dir $(LOG)
